// File: hdl/fifoSync.sv
/*
  Synchronous FIFO
  Circular buffer of a type parameterised payload with full, empty and
  half levels and a popped pulse on every accepted read
  DEPTH 0 turns it into a combinational pass-through
*/
`timescale 1ns/10ps

module fifoSync #(
  parameter int  DEPTH    = 2,              // 0, 2, 4, 8 or 16
  parameter type payloadT = logic [31:0]
) (
  input  logic    clk,
  input  logic    rest,
  input  logic    write,
  input  logic    read,
  input  payloadT writeData,
  output payloadT readData,
  output logic    full,
  output logic    empty,
  output logic    half,
  output logic    popped
);

  generate
    if (DEPTH == 0) begin : gPass
      // No storage, the writer hands straight to the reader
      assign readData = writeData;
      // Empty follows the write alone, so the reader may depend on it
      assign empty    = !write;
      assign full     = write && !read; // Offered word not taken
      assign half     = write && !read;
      assign popped   = write && read;
    end else begin : gBuf
      // Pointers carry one extra wrap bit
      localparam int PTR_W = $clog2(DEPTH) + 1;
      localparam int IDX_W = PTR_W - 1;
      localparam logic [PTR_W-1:0] HALF_LVL = PTR_W'(DEPTH / 2);

      payloadT          array [DEPTH];
      logic [PTR_W-1:0] front;  // Oldest entry
      logic [PTR_W-1:0] rear;   // Next free slot
      logic [PTR_W-1:0] count;
      logic             wrapFull;
      logic             pushOk;
      logic             popOk;

      assign count    = rear - front;
      // Same slot index on opposite wraps
      assign wrapFull = (front[PTR_W-1] != rear[PTR_W-1]) &&
                        (front[IDX_W-1:0] == rear[IDX_W-1:0]);
      // A read in the same cycle frees a slot
      assign full     = wrapFull && !read;
      assign empty    = front == rear;
      assign half     = count >= HALF_LVL;

      assign pushOk   = write && (!full || read);
      assign popOk    = read && !empty;  // Read on empty ignored
      assign popped   = popOk;

      // Head of queue always on the output
      assign readData = array[front[IDX_W-1:0]];

      always_ff @(posedge clk) begin
        if (pushOk) begin
          array[rear[IDX_W-1:0]] <= writeData;
        end
      end

      always_ff @(posedge clk or negedge rest) begin
        if (!rest) begin
          front <= '0;
          rear  <= '0;
        end else begin
          if (pushOk) begin
            rear <= rear + PTR_W'(1);
          end
          if (popOk) begin
            front <= front + PTR_W'(1);
          end
        end
      end
    end
  endgenerate

endmodule

// File: hdl/memQueuePkg.sv
/*
  Memory request queue package
  Widths of the word address, data and tag, plus the packed request
  and response payloads carried through the queue
*/
package memQueuePkg;

  // 256 word scratchpad
  parameter int ADDR_W = 8;
  parameter int DATA_W = 32;
  // Chosen by the producer, echoed in the response
  parameter int TAG_W  = 4;

  // Request as pushed by the producer, 45 bits
  typedef struct packed {
    logic              isWrite; // 1 stores data, 0 fetches a word
    logic [TAG_W-1:0]  tag;
    logic [ADDR_W-1:0] addr;    // Word address
    logic [DATA_W-1:0] data;    // Store data, ignored on a read
  } memReqT;

  // Response as seen by the consumer, 37 bits
  typedef struct packed {
    logic              wasWrite; // Copy of the request flag
    logic [TAG_W-1:0]  tag;
    // Read word, or the written data on a store
    logic [DATA_W-1:0] data;
  } memRespT;

endpackage

// File: hdl/memQueueTop.sv
/*
  Memory request queue top level
  Request FIFO, issue controller, scratchpad RAM and response FIFO in a
  single chain, one response per accepted request, in push order
*/
`timescale 1ns/10ps

module memQueueTop
  import memQueuePkg::*;
#(
  parameter int REQ_DEPTH  = 4,  // 0, 2, 4, 8 or 16
  parameter int RESP_DEPTH = 4   // 2, 4, 8 or 16
) (
  input  logic    clk,
  input  logic    rest,
  input  logic    reqWrite,
  input  memReqT  reqData,
  output logic    reqFull,
  input  logic    respRead,
  output logic    respEmpty,
  output logic    respHalf,
  output memRespT respData
);

  logic    reqEmpty;
  memReqT  reqHead;
  logic    issue;
  memReqT  issueReq;
  logic    respValid;
  memRespT ramResp;
  logic    respPopped;   // Credit return
  logic    respFull;     // Kept low by the credit scheme

  // Producer side buffer
  fifoSync #(
    .DEPTH    (REQ_DEPTH),
    .payloadT (memReqT)
  ) reqFifo (
    .clk       (clk),
    .rest      (rest),
    .write     (reqWrite),
    .read      (issue),
    .writeData (reqData),
    .readData  (reqHead),
    .full      (reqFull),
    .empty     (reqEmpty),
    .half      (),
    .popped    ()
  );

  // In order issue with one credit per response slot
  requestIssue #(
    .CREDITS (RESP_DEPTH)
  ) issueCtl (
    .clk        (clk),
    .rest       (rest),
    .reqEmpty   (reqEmpty),
    .reqHead    (reqHead),
    .respPopped (respPopped),
    .issue      (issue),
    .issueReq   (issueReq)
  );

  scratchpadRam ram (
    .clk       (clk),
    .rest      (rest),
    .issue     (issue),
    .issueReq  (issueReq),
    .respValid (respValid),
    .respData  (ramResp)
  );

  // Consumer side buffer
  fifoSync #(
    .DEPTH    (RESP_DEPTH),
    .payloadT (memRespT)
  ) respFifo (
    .clk       (clk),
    .rest      (rest),
    .write     (respValid),
    .read      (respRead),
    .writeData (ramResp),
    .readData  (respData),
    .full      (respFull),
    .empty     (respEmpty),
    .half      (respHalf),
    .popped    (respPopped)
  );

endmodule

// File: hdl/requestIssue.sv
/*
  Request issue controller
  Sends the head of the request FIFO to the RAM in order, gated by a
  credit counter sized to the response FIFO so no response is lost
*/
`timescale 1ns/10ps

module requestIssue
  import memQueuePkg::*;
#(
  parameter int CREDITS = 4      // Response slots downstream
) (
  input  logic   clk,
  input  logic   rest,
  input  logic   reqEmpty,       // From the request FIFO
  input  memReqT reqHead,        // Oldest request
  input  logic   respPopped,     // Consumer took a response
  output logic   issue,          // Also pops the request FIFO
  output memReqT issueReq
);

  // Counter has to hold CREDITS itself
  localparam int CNT_W = $clog2(CREDITS + 1);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(CREDITS);

  logic [CNT_W-1:0] credits;
  logic             hasCredit;

  // A credit is one free slot across the RAM pipe and response FIFO
  assign hasCredit = credits != '0;

  // Pure combinational issue from flag and count
  assign issue = !reqEmpty && hasCredit;

  // Head request goes straight to the RAM
  assign issueReq = reqHead;

  // Spend on issue, return on pop, both at once leave it unchanged
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      credits <= CNT_FULL;
    end else begin
      case ({issue, respPopped})
        2'b10:   credits <= credits - CNT_W'(1);
        2'b01:   credits <= credits + CNT_W'(1);
        default: credits <= credits;   // Idle or balanced
      endcase
    end
  end

endmodule

// File: hdl/scratchpadRam.sv
/*
  Scratchpad RAM
  Single port word memory with a fixed two cycle response
  Each issued request yields one response with its tag and write flag
*/
`timescale 1ns/10ps

module scratchpadRam
  import memQueuePkg::*;
(
  input  logic    clk,
  input  logic    rest,
  input  logic    issue,     // One request per cycle at most
  input  memReqT  issueReq,
  output logic    respValid,
  output memRespT respData
);

  localparam int WORDS = 2 ** ADDR_W;

  logic [DATA_W-1:0] mem [WORDS];

  // Two stage response pipeline
  logic    valid1;
  logic    valid2;
  memRespT stage1;
  memRespT stage2;

  // Memory access and first stage capture on the issue edge
  always_ff @(posedge clk) begin
    if (issue) begin
      stage1.wasWrite <= issueReq.isWrite;
      stage1.tag      <= issueReq.tag;
      if (issueReq.isWrite) begin
        mem[issueReq.addr] <= issueReq.data;
        stage1.data        <= issueReq.data;  // Store echoes its data
      end else begin
        stage1.data <= mem[issueReq.addr];     // Registered read
      end
    end
  end

  // Second stage just follows the first
  always_ff @(posedge clk) begin
    stage2 <= stage1;
  end

  // Valid bits track which stages hold a live response
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      valid1 <= 1'b0;
      valid2 <= 1'b0;
    end else begin
      valid1 <= issue;
      valid2 <= valid1;
    end
  end

  // Out two edges after issue
  assign respValid = valid2;
  assign respData  = stage2;

endmodule

// File: runSim.sh
#!/bin/bash
# Build and run the memory queue testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --timing --assert -j 0 --top-module memQueueTb \
  -f vlog.f -o simv > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log

grep -q "Done: errors found" sim.log && { echo "Simulation failed"; exit 1; }
[ "$simStatus" -eq 0 ] || { echo "Simulation stopped with status $simStatus"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"

// File: tests/memQueueTb.sv
/*
  Memory request queue testbench
  Directed tests for reset, write then read, ordering, back-pressure and
  dropped writes, checked against a reference memory and response queue
*/
`timescale 1ns/10ps

module memQueueTb
  import memQueuePkg::*;
();

  localparam int REQ_DEPTH  = 4;
  localparam int RESP_DEPTH = 4;
  localparam int TIMEOUT    = 50;    // Cycles per wait
  localparam int STREAM_MAX = 1000;  // Cycles for the ordering stream
  localparam int RUN_MAX    = 5000;  // Whole run

  logic    clk;
  logic    rest;
  logic    reqWrite;
  memReqT  reqData;
  logic    reqFull;
  logic    respRead;
  logic    respEmpty;
  logic    respHalf;
  memRespT respData;

  // Reference model state
  logic [DATA_W-1:0] refMem [2 ** ADDR_W];
  memRespT           expQ [$];    // Responses still owed, oldest first
  memReqT            reqList [$];

  integer           seed = 32'hcf369b46;
  logic [TAG_W-1:0] tagCnt;
  int               errors;
  int               checks;
  string            curTest;

  memQueueTop #(
    .REQ_DEPTH  (REQ_DEPTH),
    .RESP_DEPTH (RESP_DEPTH)
  ) UUT (
    .clk       (clk),
    .rest      (rest),
    .reqWrite  (reqWrite),
    .reqData   (reqData),
    .reqFull   (reqFull),
    .respRead  (respRead),
    .respEmpty (respEmpty),
    .respHalf  (respHalf),
    .respData  (respData)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  // Hard stop if something never settles
  initial begin
    repeat (RUN_MAX) @(posedge clk);
    $display("Simulation still running after %0d cycles, stopped", RUN_MAX);
    $display("Done: errors found");
    $finish;
  end

  task automatic checkResp(input string name, input memRespT exp, input memRespT act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected wasWrite=%0b tag=%h data=%h, actual wasWrite=%0b tag=%h data=%h",
               name, exp.wasWrite, exp.tag, exp.data, act.wasWrite, act.tag, act.data);
    end
  endtask

  task automatic checkFlag(input string name, input bit exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected %0b, actual %0b", name, exp, act);
    end
  endtask

  task automatic checkCount(input string name, input int exp, input int act);
    checks++;
    if (act != exp) begin
      errors++;
      $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  // New request with the next tag
  function automatic memReqT makeReq(input bit isWrite, input logic [ADDR_W-1:0] addr,
                                     input logic [DATA_W-1:0] data);
    memReqT r;
    r.isWrite = isWrite;
    r.tag     = tagCnt;
    r.addr    = addr;
    r.data    = data;
    tagCnt    = tagCnt + 1'b1;
    return r;
  endfunction

  // Accepted request, work out what the queue owes for it
  task automatic modelReq(input memReqT req);
    memRespT e;
    e.wasWrite = req.isWrite;
    e.tag      = req.tag;
    if (req.isWrite) begin
      e.data           = req.data;   // Store echoes data
      refMem[req.addr] = req.data;
    end else begin
      e.data = refMem[req.addr];
    end
    expQ.push_back(e);
  endtask

  task automatic takeResp(input memRespT act);
    memRespT exp;
    if (expQ.size() == 0) begin
      errors++;
      $display("Test %s: a response came out with no request outstanding", curTest);
    end else begin
      exp = expQ.pop_front();
      checkResp(curTest, exp, act);
    end
  endtask

  // One clock of stimulus, entered and left 2 ns after a rising edge
  task automatic driveCycle(input bit doPush, input memReqT req, input bit doPop,
                            output bit pushed, output bit pulled);
    reqWrite = doPush;
    reqData  = req;
    respRead = doPop;
    @(negedge clk);                   // Flags settled mid cycle
    pushed = doPush && !reqFull;
    pulled = doPop && !respEmpty;
    if (pulled) takeResp(respData);   // Pop first, it is older
    if (pushed) modelReq(req);
    @(posedge clk);
    #2;
    reqWrite = 1'b0;
    respRead = 1'b0;
  endtask

  task automatic pushReq(input memReqT req);
    bit pushed;
    bit pulled;
    int tries;
    tries  = 0;
    pushed = 1'b0;
    while (!pushed && tries < TIMEOUT) begin
      driveCycle(1'b1, req, 1'b0, pushed, pulled);
      tries++;
    end
    if (!pushed) begin
      errors++;
      $display("Test %s: request tag %h was never accepted", curTest, req.tag);
    end
  endtask

  task automatic popResp();
    bit pushed;
    bit pulled;
    int waitCnt;
    waitCnt = 0;
    while (respEmpty && waitCnt < TIMEOUT) begin
      @(posedge clk);
      #2;
      waitCnt++;
    end
    if (respEmpty) begin
      errors++;
      $display("Test %s: no response arrived within %0d cycles", curTest, TIMEOUT);
    end else begin
      driveCycle(1'b0, '0, 1'b1, pushed, pulled);
    end
  endtask

  // Pop everything owed, then make sure nothing extra shows up
  task automatic drainAll();
    bit pushed;
    bit pulled;
    int waitCnt;
    waitCnt = 0;
    while (expQ.size() > 0 && waitCnt < TIMEOUT) begin
      driveCycle(1'b0, '0, 1'b1, pushed, pulled);
      waitCnt++;
    end
    if (expQ.size() > 0) begin
      errors++;
      $display("Test %s: %0d responses still missing after draining", curTest, expQ.size());
      expQ.delete();
    end
    repeat (4) @(posedge clk);   // Room for a stray response
    #2;
    checkFlag({curTest, " respEmpty after drain"}, 1'b1, respEmpty);
  endtask

  // Reads until a push is refused, the refused one is dropped
  task automatic fillQueue(output int accepted);
    bit pushed;
    bit pulled;
    int tries;
    accepted = 0;
    tries    = 0;
    pushed   = 1'b1;
    while (pushed && tries < TIMEOUT) begin
      driveCycle(1'b1, makeReq(1'b0, ADDR_W'(tries % 16), '0), 1'b0, pushed, pulled);
      if (pushed) accepted++;
      tries++;
    end
  endtask

  task automatic endTest(input int errStart);
    if (errors == errStart) $display("Test %s: passed", curTest);
    else $display("Test %s: failed with %0d errors", curTest, errors - errStart);
  endtask

  task automatic testReset();
    int errStart;
    errStart = errors;
    curTest  = "reset";
    checkFlag("reset reqFull", 1'b0, reqFull);
    checkFlag("reset respEmpty", 1'b1, respEmpty);
    checkFlag("reset respHalf", 1'b0, respHalf);
    endTest(errStart);
  endtask

  task automatic testWriteRead();
    int                errStart;
    logic [DATA_W-1:0] d;
    errStart = errors;
    curTest  = "writeRead";
    d        = $random(seed);
    pushReq(makeReq(1'b1, 8'hA5, d));
    pushReq(makeReq(1'b0, 8'hA5, '0));
    popResp();   // Write echo
    popResp();   // Stored word
    endTest(errStart);
  endtask

  task automatic testOrdering();
    int          errStart;
    int          sent;
    int          cycles;
    bit          pushed;
    bit          pulled;
    logic [31:0] r;
    memReqT      nextReq;
    errStart = errors;
    curTest  = "ordering";
    reqList.delete();
    for (int i = 0; i < 16; i++) begin   // Known contents first
      reqList.push_back(makeReq(1'b1, ADDR_W'(i), $random(seed)));
    end
    for (int i = 0; i < 40; i++) begin
      r = $random(seed);
      reqList.push_back(makeReq(r[5], {4'h0, r[4:1]}, $random(seed)));
    end
    sent   = 0;
    cycles = 0;
    while ((sent < reqList.size() || expQ.size() > 0) && cycles < STREAM_MAX) begin
      r       = $random(seed);
      nextReq = (sent < reqList.size()) ? reqList[sent] : '0;
      // Consumer reads about three cycles in four
      driveCycle(sent < reqList.size(), nextReq, r[0] | r[1], pushed, pulled);
      if (pushed) sent++;
      cycles++;
    end
    if (cycles >= STREAM_MAX) begin
      errors++;
      $display("Test %s: stream stalled, %0d of %0d pushed, %0d responses owed",
               curTest, sent, reqList.size(), expQ.size());
      expQ.delete();
    end
    endTest(errStart);
  endtask

  task automatic testBackPressure();
    int errStart;
    int accepted;
    errStart = errors;
    curTest  = "backPressure";
    fillQueue(accepted);   // respRead stays low
    checkCount("backPressure accepted", REQ_DEPTH + RESP_DEPTH, accepted);
    @(negedge clk);
    checkFlag("backPressure reqFull", 1'b1, reqFull);
    checkFlag("backPressure respHalf", 1'b1, respHalf);
    @(posedge clk);
    #2;
    drainAll();
    endTest(errStart);
  endtask

  task automatic testDropOnFull();
    int                errStart;
    int                accepted;
    bit                pushed;
    bit                pulled;
    logic [DATA_W-1:0] d;
    errStart = errors;
    curTest  = "dropOnFull";
    fillQueue(accepted);
    d = $random(seed);
    driveCycle(1'b1, makeReq(1'b1, 8'h03, d), 1'b0, pushed, pulled);
    checkFlag("dropOnFull write accepted", 1'b0, pushed);
    drainAll();
    pushReq(makeReq(1'b0, 8'h03, '0));   // Old word expected
    popResp();
    endTest(errStart);
  endtask

  initial begin
    rest     = 1'b0;
    reqWrite = 1'b0;
    reqData  = '0;
    respRead = 1'b0;
    tagCnt   = '0;
    errors   = 0;
    checks   = 0;
    curTest  = "none";
    repeat (5) @(posedge clk);
    #2;
    rest = 1'b1;

    testReset();
    testWriteRead();
    testOrdering();
    testBackPressure();
    testDropOnFull();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: tests/memQueue_sva.sv
/*
  Memory queue assertions
  RAM response latency, response FIFO overflow and issue from an empty
  request FIFO, bound into the queue top level
*/
`timescale 1ns/10ps

module memQueueSva
  import memQueuePkg::*;
(
  input logic clk,
  input logic rest,
  input logic reqWrite,
  input logic reqFull,
  input logic issue,
  input logic respValid,
  input logic respFull
);

  // Request FIFO occupancy rebuilt from its strobes
  int reqCount;

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      reqCount <= 0;
    end else begin
      reqCount <= reqCount + int'(reqWrite && !reqFull) - int'(issue);
    end
  end

  // Fixed two edge RAM latency
  issueToResp: assert property (
    @(posedge clk) disable iff (!rest)
    $past(issue, 2) |-> respValid
  ) else $error("respValid missing two cycles after issue");

  // Credits keep a slot free for every response in flight
  noRespOverflow: assert property (
    @(posedge clk) disable iff (!rest)
    respValid |-> !respFull
  ) else $error("respValid while the response FIFO is full");

  // Pass-through mode may issue the incoming write directly
  noIssueEmpty: assert property (
    @(posedge clk) disable iff (!rest)
    issue |-> (reqCount > 0) || reqWrite
  ) else $error("issue while the request FIFO is empty");

endmodule

bind memQueueTop memQueueSva assertChk (
  .clk       (clk),
  .rest      (rest),
  .reqWrite  (reqWrite),
  .reqFull   (reqFull),
  .issue     (issue),
  .respValid (respValid),
  .respFull  (respFull)
);

// File: vlog.f
hdl/memQueuePkg.sv
hdl/fifoSync.sv
hdl/scratchpadRam.sv
hdl/requestIssue.sv
hdl/memQueueTop.sv
tests/memQueue_sva.sv
tests/memQueueTb.sv
